/* dcache_pkg.sv */
package dcache_pkg;

    // Core word width
    localparam int WORD_BITS = 32;

    // Cache line geometry
    // 16 bytes per line
    localparam int OFFSET_BITS = 4;
    localparam int LINE_BITS   = 128;

    // Memory must answer no sooner than this many cycles after a request
    localparam int MEM_LATENCY_MIN = 2;

    // Data word or byte address
    typedef logic [WORD_BITS-1:0] word_t;

    // Whole cache line as moved to and from memory
    typedef logic [LINE_BITS-1:0] line_t;

    // Access size code
    typedef logic [1:0] size_t;

    // Signed byte
    // Loads sign-extend bit 7 of the addressed byte
    localparam size_t SIZE_BYTE = 2'b00;

    // Aligned full word
    localparam size_t SIZE_WORD = 2'b10;

endpackage

/* sb_drain_if.sv */
`timescale 1ns/1ps

interface sb_drain_if import dcache_pkg::*; ();

    // Oldest buffered store
    word_t value;
    word_t addr;
    size_t size;

    // Head entry is valid
    logic  wenable;

    // Cache took the entry at this edge
    logic  store_success;

    // Store buffer side
    modport sb (
        output value, addr, size, wenable,
        input  store_success
    );

    // Cache side
    modport cache (
        input  value, addr, size, wenable,
        output store_success
    );

endinterface

/* dcache.sv */
`timescale 1ns/1ps

module dcache import dcache_pkg::*; #(
    parameter int N_SETS     = 4,
    parameter int SB_ENTRIES = 4
) (
    input  logic      clk,
    input  logic      rst,
    // Lookup from the merge unit
    input  logic      lookup_valid,
    input  logic      store,
    input  word_t     addr,
    input  size_t     size,
    output logic      hit,
    output logic      store_stall,
    output word_t     cache_data,
    // Line requests and responses
    output logic      mem_req,
    output word_t     mem_req_addr,
    input  logic      mem_res,
    input  word_t     mem_res_addr,
    input  line_t     mem_res_data,
    // Dirty line write-back
    output logic      mem_write,
    output word_t     mem_write_addr,
    output line_t     mem_write_data,
    // Write port from the store buffer
    sb_drain_if.cache drain
);

    localparam int SET_BITS = $clog2(N_SETS);
    localparam int TAG_BITS = WORD_BITS - OFFSET_BITS - SET_BITS;
    // One extra bit so a line can hold every buffered store
    localparam int PIN_BITS = $clog2(SB_ENTRIES) + 1;

    typedef logic [SET_BITS-1:0]    set_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [PIN_BITS-1:0]    pin_t;

    // Resident lines, no valid bit
    tag_t              tags    [N_SETS];
    line_t             data    [N_SETS];
    logic [N_SETS-1:0] dirty;
    // Buffered stores still waiting to be written into the line
    pin_t              pin_cnt [N_SETS];

    // Outstanding miss per set
    logic [N_SETS-1:0] mr_present;
    tag_t              mr_tag  [N_SETS];
    // Stores accepted for the line before it arrives
    pin_t              mr_pins [N_SETS];

    // Address fields of the lookup
    tag_t    tag;
    set_t    set;
    offset_t offset;

    // Address fields of the drained store
    tag_t    sb_tag;
    set_t    sb_set;
    offset_t sb_offset;

    // Address fields of the arriving line
    tag_t    res_tag;
    set_t    res_set;

    line_t       cur_line;
    line_t       drain_line;
    logic [7:0]  byte_val;
    logic        pend_match;
    logic        res_install;
    logic        pin_inc;
    logic        pend_inc;

    // One-hot set selects for the per-set update
    logic [N_SETS-1:0] res_sel;
    logic [N_SETS-1:0] req_sel;
    logic [N_SETS-1:0] pin_sel;
    logic [N_SETS-1:0] pend_sel;
    logic [N_SETS-1:0] drain_sel;

    assign {tag, set, offset}          = addr;
    assign {sb_tag, sb_set, sb_offset} = drain.addr;
    assign res_set = mem_res_addr[OFFSET_BITS +: SET_BITS];
    assign res_tag = mem_res_addr[OFFSET_BITS+SET_BITS +: TAG_BITS];

    assign cur_line   = data[set];
    assign hit        = lookup_valid && tags[set] == tag;
    assign pend_match = mr_present[set] && mr_tag[set] == tag;

    // One request per set, and never while the old line is pinned
    assign mem_req      = lookup_valid && !hit && !mr_present[set] && pin_cnt[set] == '0;
    assign mem_req_addr = {tag, set, {OFFSET_BITS{1'b0}}};

    // Store is taken if its line is resident and stays, or is being fetched
    // A resident line with a pending replacement must not gain pins
    assign store_stall = lookup_valid && store &&
                         !((hit && !mr_present[set]) || mem_req || pend_match);
    assign pin_inc  = lookup_valid && store && hit && !mr_present[set];
    assign pend_inc = lookup_valid && store && pend_match;

    // Load data
    always_comb begin
        byte_val = cur_line[{offset, 3'b000} +: 8];
        if (size == SIZE_BYTE) begin
            cache_data = {{24{byte_val[7]}}, byte_val};
        end else begin
            cache_data = cur_line[{offset[OFFSET_BITS-1:2], 5'b00000} +: WORD_BITS];
        end
    end

    // Drain only into the right line, and not while a fill writes the array
    assign drain.store_success = drain.wenable && tags[sb_set] == sb_tag && !mem_res;

    // Line with the head store merged in
    always_comb begin
        drain_line = data[sb_set];
        if (drain.size == SIZE_BYTE) begin
            drain_line[{sb_offset, 3'b000} +: 8] = drain.value[7:0];
        end else begin
            drain_line[{sb_offset[OFFSET_BITS-1:2], 5'b00000} +: WORD_BITS] = drain.value;
        end
    end

    // Responses without a matching miss record are ignored
    assign res_install = mem_res && mr_present[res_set];

    // Old line leaves in the same cycle its replacement arrives
    assign mem_write      = res_install && dirty[res_set];
    assign mem_write_addr = {tags[res_set], res_set, {OFFSET_BITS{1'b0}}};
    assign mem_write_data = data[res_set];

    assign res_sel   = N_SETS'(res_install) << res_set;
    assign req_sel   = N_SETS'(mem_req) << set;
    assign pin_sel   = N_SETS'(pin_inc) << set;
    assign pend_sel  = N_SETS'(pend_inc) << set;
    assign drain_sel = N_SETS'(drain.store_success) << sb_set;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < N_SETS; s++) begin
                tags[s]    <= '0;
                data[s]    <= '0;
                pin_cnt[s] <= '0;
                mr_tag[s]  <= '0;
                mr_pins[s] <= '0;
            end
            dirty      <= '0;
            mr_present <= '0;
        end else begin
            for (int s = 0; s < N_SETS; s++) begin
                if (res_sel[s]) begin
                    // Install the line and hand over the pending pins
                    tags[s]       <= res_tag;
                    data[s]       <= mem_res_data;
                    dirty[s]      <= 1'b0;
                    pin_cnt[s]    <= mr_pins[s] + pin_t'(pend_sel[s]);
                    mr_present[s] <= 1'b0;
                    mr_pins[s]    <= '0;
                end else begin
                    if (drain_sel[s]) begin
                        data[s]  <= drain_line;
                        dirty[s] <= 1'b1;
                    end
                    // Store hit and drain may meet on the same set
                    pin_cnt[s] <= pin_cnt[s] + pin_t'(pin_sel[s]) - pin_t'(drain_sel[s]);
                    if (req_sel[s]) begin
                        mr_present[s] <= 1'b1;
                        mr_tag[s]     <= tag;
                        // Load misses fetch an unpinned line
                        mr_pins[s]    <= pin_t'(store);
                    end else if (pend_sel[s]) begin
                        mr_pins[s] <= mr_pins[s] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* store_buffer.sv */
`timescale 1ns/1ps

module store_buffer import dcache_pkg::*; #(
    parameter int SB_ENTRIES = 4
) (
    input  logic   clk,
    input  logic   rst,
    // Store entry, and lookup address for forwarding
    input  logic   push,
    input  word_t  addr,
    input  size_t  size,
    input  word_t  wdata,
    output logic   full,
    output logic   empty,
    // Forwarding result for the lookup
    output logic   fwd_hit,
    output logic   fwd_conflict,
    output word_t  fwd_data,
    // Head entry toward the cache
    sb_drain_if.sb drain
);

    localparam int PTR_BITS = $clog2(SB_ENTRIES);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [PTR_BITS:0]   cnt_t;

    // Entry payload
    word_t ent_addr  [SB_ENTRIES];
    size_t ent_size  [SB_ENTRIES];
    word_t ent_value [SB_ENTRIES];

    ptr_t  head;
    ptr_t  tail;
    cnt_t  count;
    logic  push_ok;
    logic  pop;

    // Slot of the k-th oldest entry
    ptr_t  slot [SB_ENTRIES];
    logic  any_match;
    ptr_t  young;

    // Wraps for any depth, not only powers of two
    function automatic ptr_t bump(input ptr_t p);
        bump = (p == ptr_t'(SB_ENTRIES - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = count == cnt_t'(SB_ENTRIES);
    assign empty   = count == '0;
    assign push_ok = push && !full;
    assign pop     = drain.wenable && drain.store_success;

    // Head is always on offer while anything is buffered
    assign drain.wenable = !empty;
    assign drain.addr    = ent_addr[head];
    assign drain.size    = ent_size[head];
    assign drain.value   = ent_value[head];

    always_comb begin
        for (int k = 0; k < SB_ENTRIES; k++) begin
            slot[k] = ptr_t'((int'(head) + k) % SB_ENTRIES);
        end
    end

    // Scan oldest to youngest so the last match wins
    always_comb begin
        any_match = 1'b0;
        young     = head;
        for (int k = 0; k < SB_ENTRIES; k++) begin
            if (cnt_t'(k) < count && ent_addr[slot[k]][31:2] == addr[31:2]) begin
                any_match = 1'b1;
                young     = slot[k];
            end
        end
    end

    // Only a full word can be forwarded whole, anything else must drain first
    assign fwd_hit      = any_match && ent_size[young] == SIZE_WORD && size == SIZE_WORD;
    assign fwd_conflict = any_match && !fwd_hit;
    assign fwd_data     = ent_value[young];

    // Payload slots
    always_ff @(posedge clk) begin
        if (push_ok) begin
            ent_addr[tail]  <= addr;
            ent_size[tail]  <= size;
            ent_value[tail] <= wdata;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_ok) begin
                tail <= bump(tail);
            end
            if (pop) begin
                head <= bump(head);
            end
            count <= count + cnt_t'(push_ok) - cnt_t'(pop);
        end
    end

endmodule

/* load_merge.sv */
`timescale 1ns/1ps

module load_merge import dcache_pkg::*; (
    // Request from the pipeline
    input  logic       req_valid,
    input  logic       req_store,
    input  size_t      req_size,
    input  logic [1:0] req_addr_byte,
    // Cache status
    input  logic       hit,
    input  logic       store_stall,
    // Store buffer status
    input  logic       sb_full,
    input  logic       fwd_hit,
    input  logic       fwd_conflict,
    // Candidate load values
    input  word_t      cache_data,
    input  word_t      fwd_data,
    output logic       lookup_valid,
    output logic       push,
    output logic       req_done,
    output word_t      rd_data
);

    logic load_done;

    // A refused store must not pin a line or start a fetch
    assign lookup_valid = req_valid && !(req_store && sb_full);

    assign push = req_valid && req_store && !sb_full && !store_stall;

    // Older overlapping stores that cannot forward hold the load back
    assign load_done = req_valid && !req_store && (fwd_hit || (hit && !fwd_conflict));

    assign req_done = push || load_done;

    // A forward only ever carries a whole word
    always_comb begin
        if (!fwd_hit) begin
            rd_data = cache_data;
        end else begin
            rd_data = fwd_data;
        end
    end

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import dcache_pkg::*; #(
    parameter int N_SETS     = 4,
    parameter int SB_ENTRIES = 4
) (
    input  logic  clk,
    input  logic  rst,
    // Load/store request
    input  logic  req_valid,
    input  logic  req_store,
    input  word_t req_addr,
    input  size_t req_size,
    input  word_t req_wdata,
    output logic  req_done,
    output word_t rd_data,
    // Memory side
    output logic  mem_req,
    output word_t mem_req_addr,
    input  logic  mem_res,
    input  word_t mem_res_addr,
    input  line_t mem_res_data,
    output logic  mem_write,
    output word_t mem_write_addr,
    output line_t mem_write_data,
    output logic  sb_empty
);

    logic  lookup_valid;
    logic  push;
    logic  hit;
    logic  store_stall;
    word_t cache_data;
    logic  sb_full;
    logic  fwd_hit;
    logic  fwd_conflict;
    word_t fwd_data;

    // Store buffer to cache write port
    sb_drain_if drain_bus ();

    dcache #(
        .N_SETS     (N_SETS),
        .SB_ENTRIES (SB_ENTRIES)
    ) u_dcache (
        .clk            (clk),
        .rst            (rst),
        .lookup_valid   (lookup_valid),
        .store          (req_store),
        .addr           (req_addr),
        .size           (req_size),
        .hit            (hit),
        .store_stall    (store_stall),
        .cache_data     (cache_data),
        .mem_req        (mem_req),
        .mem_req_addr   (mem_req_addr),
        .mem_res        (mem_res),
        .mem_res_addr   (mem_res_addr),
        .mem_res_data   (mem_res_data),
        .mem_write      (mem_write),
        .mem_write_addr (mem_write_addr),
        .mem_write_data (mem_write_data),
        .drain          (drain_bus.cache)
    );

    store_buffer #(
        .SB_ENTRIES (SB_ENTRIES)
    ) u_store_buffer (
        .clk          (clk),
        .rst          (rst),
        .push         (push),
        .addr         (req_addr),
        .size         (req_size),
        .wdata        (req_wdata),
        .full         (sb_full),
        .empty        (sb_empty),
        .fwd_hit      (fwd_hit),
        .fwd_conflict (fwd_conflict),
        .fwd_data     (fwd_data),
        .drain        (drain_bus.sb)
    );

    // Low address bits give the byte within the word
    load_merge u_load_merge (
        .req_valid     (req_valid),
        .req_store     (req_store),
        .req_size      (req_size),
        .req_addr_byte (req_addr[1:0]),
        .hit           (hit),
        .store_stall   (store_stall),
        .sb_full       (sb_full),
        .fwd_hit       (fwd_hit),
        .fwd_conflict  (fwd_conflict),
        .cache_data    (cache_data),
        .fwd_data      (fwd_data),
        .lookup_valid  (lookup_valid),
        .push          (push),
        .req_done      (req_done),
        .rd_data       (rd_data)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // Starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

/* mem_stage_sva.sv */
`timescale 1ns/1ps

module mem_stage_sva import dcache_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  req_done,
    input logic  mem_req,
    input word_t mem_req_addr,
    input logic  mem_res,
    input word_t mem_res_addr,
    input logic  mem_write
);

    // One request per miss, never repeated on the next cycle
    assert property (@(posedge clk) disable iff (rst)
        mem_req |=> !(mem_req && mem_req_addr == $past(mem_req_addr)))
        else $error("mem_req repeated for the same line address");

    // Write-back only together with the replacing line
    assert property (@(posedge clk) disable iff (rst) mem_write |-> mem_res)
        else $error("mem_write without mem_res");

    assert property (@(posedge clk) rst |-> !req_done)
        else $error("req_done high during reset");

    // Memory model must respect the minimum latency
    for (genvar d = 1; d < MEM_LATENCY_MIN; d++) begin : g_latency
        assert property (@(posedge clk) disable iff (rst)
            mem_res |-> !($past(mem_req, d) && $past(mem_req_addr, d) == mem_res_addr))
            else $error("memory response arrived too soon");
    end

endmodule

/* mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb import dcache_pkg::*;;

    localparam int N_SETS         = 4;
    localparam int SB_ENTRIES     = 4;
    localparam int MEM_LATENCY    = MEM_LATENCY_MIN + 2;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int RAND_OPS       = 200;
    // Two tags for every set
    localparam int RAND_SPAN      = 2 * N_SETS * 16;
    localparam word_t RAND_BASE   = 32'h0000_4000;

    logic  clk;
    logic  rst;
    logic  req_valid;
    logic  req_store;
    word_t req_addr;
    size_t req_size;
    word_t req_wdata;
    logic  req_done;
    word_t rd_data;
    logic  mem_req;
    word_t mem_req_addr;
    logic  mem_res;
    word_t mem_res_addr;
    line_t mem_res_data;
    logic  mem_write;
    word_t mem_write_addr;
    line_t mem_write_data;
    logic  sb_empty;

    // Backing memory and architectural reference, unwritten bytes use the fill
    logic [7:0] mem_bytes [word_t];
    logic [7:0] ref_bytes [word_t];
    word_t      pend_addr [$];
    int         pend_due  [$];
    int         cyc = 0;
    int         wb_count = 0;
    word_t      last_wb_addr;
    line_t      last_wb_data;
    int         seed = 9767;

    tb_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

    mem_stage #(.N_SETS(N_SETS), .SB_ENTRIES(SB_ENTRIES)) UUT (.*);

    bind mem_stage mem_stage_sva u_sva (
        .clk(clk), .rst(rst), .req_done(req_done), .mem_req(mem_req),
        .mem_req_addr(mem_req_addr), .mem_res(mem_res),
        .mem_res_addr(mem_res_addr), .mem_write(mem_write)
    );

    function automatic logic [7:0] fill_byte(input word_t a);
        word_t h;
        h = (a ^ (a >> 16)) * 32'h9E37_79B1;
        h = h ^ (h >> 13);
        return h[7:0] ^ h[31:24];
    endfunction

    function automatic logic [7:0] mem_byte(input word_t a);
        return mem_bytes.exists(a) ? mem_bytes[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] ref_byte(input word_t a);
        return ref_bytes.exists(a) ? ref_bytes[a] : fill_byte(a);
    endfunction

    // Little endian, byte 0 in the low bits
    function automatic word_t ref_word(input word_t a);
        return {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
    endfunction

    function automatic word_t expect_load(input word_t a, input size_t sz);
        logic [7:0] b;
        b = ref_byte(a);
        if (sz == SIZE_BYTE) begin
            return {{24{b[7]}}, b};
        end
        return ref_word(a);
    endfunction

    function automatic void ref_store(input word_t a, input size_t sz, input word_t wd);
        ref_bytes[a] = wd[7:0];
        if (sz == SIZE_WORD) begin
            for (int i = 1; i < 4; i++) begin
                ref_bytes[a + i] = wd[i*8 +: 8];
            end
        end
    endfunction

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // Answers each request after a fixed latency, absorbs write-backs
    initial begin : memory_model
        line_t line;
        word_t base;
        mem_res      = 1'b0;
        mem_res_addr = '0;
        mem_res_data = '0;
        forever begin
            @(negedge clk);
            cyc++;
            mem_res = 1'b0;
            if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
                base = pend_addr.pop_front();
                void'(pend_due.pop_front());
                for (int i = 0; i < 16; i++) begin
                    line[i*8 +: 8] = mem_byte(base + i);
                end
                mem_res      = 1'b1;
                mem_res_addr = base;
                mem_res_data = line;
            end
            // Mid low phase, outputs settled
            #10;
            if (mem_write) begin
                for (int i = 0; i < 16; i++) begin
                    mem_bytes[mem_write_addr + i] = mem_write_data[i*8 +: 8];
                end
                wb_count++;
                last_wb_addr = mem_write_addr;
                last_wb_data = mem_write_data;
            end
            if (mem_req) begin
                pend_addr.push_back(mem_req_addr);
                pend_due.push_back(cyc + MEM_LATENCY);
            end
        end
    end

    task automatic start_req(input logic st, input word_t a, input size_t sz, input word_t wd);
        @(negedge clk);
        req_valid = 1'b1;
        req_store = st;
        req_addr  = a;
        req_size  = sz;
        req_wdata = wd;
    endtask

    // Request stays on the inputs until the edge after req_done
    task automatic wait_done(output word_t rd, output int waits);
        int n;
        n = 0;
        #10;
        while (!req_done) begin
            if (n == TIMEOUT_CYCLES) begin
                timeout_fail("req_done");
            end
            n++;
            @(negedge clk);
            #10;
        end
        rd    = rd_data;
        waits = n;
    endtask

    task automatic access(input logic st, input word_t a, input size_t sz, input word_t wd,
                          output word_t rd, output int waits);
        start_req(st, a, sz, wd);
        wait_done(rd, waits);
        if (st) begin
            ref_store(a, sz, wd);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        req_valid = 1'b0;
        #10;
        while (!sb_empty) begin
            if (n == TIMEOUT_CYCLES) begin
                timeout_fail("sb_empty");
            end
            n++;
            @(negedge clk);
            #10;
        end
    endtask

    task automatic reset_and_first_miss(input word_t a);
        word_t rd;
        int    waits;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        #10;
        compare_value("sb_empty", sb_empty, 1);
        compare_value("mem_req", mem_req, 0);
        compare_value("mem_write", mem_write, 0);
        compare_value("req_done", req_done, 0);
        start_req(1'b0, a, SIZE_WORD, '0);
        #10;
        compare_value("mem_req", mem_req, 1);
        compare_value("mem_req_addr", mem_req_addr, a & ~word_t'(15));
        compare_value("req_done", req_done, 0);
        @(negedge clk);
        wait_done(rd, waits);
        compare_value("rd_data word after fill", rd, expect_load(a, SIZE_WORD));
    endtask

    task automatic fill_byte_load(input word_t a);
        word_t      line;
        word_t      rd;
        word_t      ba;
        logic [7:0] b;
        int         waits;
        logic       found;
        line  = a & ~word_t'(15);
        found = 1'b0;
        ba    = line;
        // Pick a byte with bit 7 set so sign extension shows
        for (int i = 0; i < 16; i++) begin
            b = ref_byte(line + i);
            if (!found && b[7]) begin
                found = 1'b1;
                ba    = line + i;
            end
        end
        compare_value("byte of 0x80 or above in line", word_t'(found), 1);
        access(1'b0, ba, SIZE_BYTE, '0, rd, waits);
        compare_value("rd_data signed byte", rd, expect_load(ba, SIZE_BYTE));
    endtask

    task automatic forward_and_conflict(input word_t a);
        word_t rd;
        int    waits;
        access(1'b1, a, SIZE_WORD, 32'hCAFE_F00D, rd, waits);
        access(1'b0, a, SIZE_WORD, '0, rd, waits);
        compare_value("rd_data forwarded word", rd, 32'hCAFE_F00D);
        compare_value("forwarded load wait cycles", waits, 0);
        // Partial store blocks forwarding until it drains
        access(1'b1, a + 1, SIZE_BYTE, 32'h0000_005A, rd, waits);
        access(1'b0, a, SIZE_WORD, '0, rd, waits);
        compare_value("conflicting load stalled", word_t'(waits > 0), 1);
        compare_value("sb_empty at merged load", sb_empty, 1);
        compare_value("rd_data merged word", rd, expect_load(a, SIZE_WORD));
        wait_drain();
    endtask

    task automatic dirty_eviction(input word_t a);
        word_t line;
        word_t rd;
        int    waits;
        int    wb_before;
        line = a & ~word_t'(15);
        access(1'b1, a, SIZE_WORD, 32'h1357_9BDF, rd, waits);
        wait_drain();
        wb_before = wb_count;
        // Same set, next tag
        access(1'b0, line + N_SETS * 16, SIZE_WORD, '0, rd, waits);
        compare_value("mem_write count", wb_count, wb_before + 1);
        compare_value("mem_write_addr", last_wb_addr, line);
        for (int i = 0; i < 4; i++) begin
            compare_value("mem_write_data word", last_wb_data[i*32 +: 32], ref_word(line + 4 * i));
        end
        access(1'b0, a, SIZE_WORD, '0, rd, waits);
        compare_value("rd_data after reload", rd, 32'h1357_9BDF);
    endtask

    task automatic back_pressure(input word_t line);
        word_t rd;
        int    waits;
        for (int i = 0; i < SB_ENTRIES + 2; i++) begin
            access(1'b1, line + 4 * (i % 4), SIZE_WORD, 32'hB000_0000 + i, rd, waits);
            if (i == SB_ENTRIES) begin
                compare_value("store held while buffer full", word_t'(waits > 0), 1);
            end
        end
        wait_drain();
        for (int i = 0; i < 4; i++) begin
            access(1'b0, line + 4 * i, SIZE_WORD, '0, rd, waits);
            compare_value("rd_data after back-pressure", rd, expect_load(line + 4 * i, SIZE_WORD));
        end
    endtask

    task automatic random_traffic();
        word_t r;
        word_t a;
        word_t wd;
        word_t rd;
        size_t sz;
        int    waits;
        for (int k = 0; k < RAND_OPS; k++) begin
            r  = $random(seed);
            wd = $random(seed);
            a  = RAND_BASE + (r >> 8) % RAND_SPAN;
            sz = r[0] ? SIZE_WORD : SIZE_BYTE;
            if (sz == SIZE_WORD) begin
                a[1:0] = 2'b00;
            end
            access(r[1], a, sz, wd, rd, waits);
            if (!r[1]) begin
                compare_value("rd_data random load", rd, expect_load(a, sz));
            end
        end
        wait_drain();
    endtask

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_addr  = '0;
        req_size  = SIZE_WORD;
        req_wdata = '0;
        reset_and_first_miss(32'h0000_1238);
        fill_byte_load(32'h0000_1238);
        forward_and_conflict(32'h0000_123C);
        dirty_eviction(32'h0000_2048);
        back_pressure(32'h0000_3050);
        random_traffic();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* mem_stage.f */
dcache_pkg.sv
sb_drain_if.sv
dcache.sv
store_buffer.sv
load_merge.sv
mem_stage.sv
tb_clock_gen.sv
mem_stage_sva.sv
mem_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f mem_stage.f --top-module mem_stage_tb -Mdir obj_dir

# A failing run still leaves its log for the search below
./obj_dir/Vmem_stage_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
